// ==== rtl/ooo_cfg.svh ====
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// Station depth, also the reset value of each credit counter
`define OOO_RS_DEPTH 4
`define OOO_ADD_LAT  1
`define OOO_MUL_LAT  3
`define OOO_DIV_LAT  8
`define OOO_BR_LAT   1
`define OOO_XLEN     32
`define OOO_TAG_W    8
`define OOO_CREDIT_W 3

`endif

// ==== rtl/ooo_pkg.sv ====
package ooo_pkg;

    // RV32 major opcodes, zero is used as NOP
    typedef enum logic [6:0] {
        OPC_NOP    = 7'b0000000,
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // Execution unit kind, doubles as index into per-unit buses
    typedef enum logic [1:0] {
        UNIT_ADD = 2'd0,
        UNIT_MUL = 2'd1,
        UNIT_DIV = 2'd2,
        UNIT_BR  = 2'd3
    } unit_e;

endpackage

// ==== rtl/dispatch_decoder.sv ====
`include "ooo_cfg.svh"

module dispatch_decoder (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  ooo_pkg::opcode_e          in_opcode,
    input  logic [2:0]                in_func3,
    input  logic [6:0]                in_funct7,
    input  logic [`OOO_XLEN-1:0]      in_pc,
    input  logic [`OOO_XLEN-1:0]      in_op1,
    input  logic [`OOO_XLEN-1:0]      in_op2,
    input  logic [`OOO_XLEN-1:0]      in_imm,
    input  logic [`OOO_TAG_W-1:0]     in_tag,
    input  logic                      in_pred_taken,
    output logic                      in_ready,
    output logic [3:0]                rs_push,
    output ooo_pkg::opcode_e          rs_opcode [4],
    output logic [2:0]                rs_func3 [4],
    output logic [6:0]                rs_funct7 [4],
    output logic [`OOO_XLEN-1:0]      rs_pc [4],
    output logic [`OOO_XLEN-1:0]      rs_op1 [4],
    output logic [`OOO_XLEN-1:0]      rs_op2 [4],
    output logic [`OOO_XLEN-1:0]      rs_imm [4],
    output logic [`OOO_TAG_W-1:0]     rs_tag [4],
    output logic [3:0]                rs_pred_taken,
    input  logic [3:0]                rs_credit
);
    import ooo_pkg::*;

    localparam int CW = `OOO_CREDIT_W;

    unit_e         target;
    logic          is_nop;
    logic [3:0]    push_now;
    logic [CW-1:0] credit_cnt [4];

    // Routing by opcode, funct7 and func3
    always_comb begin
        target = UNIT_ADD;
        is_nop = 1'b0;
        case (in_opcode)
            OPC_NOP: is_nop = 1'b1;
            OPC_OP: begin
                if (in_funct7 == 7'b0000001 && in_func3 == 3'b000) begin
                    target = UNIT_MUL;
                end else if (in_funct7 == 7'b0000001 &&
                             (in_func3 == 3'b100 || in_func3 == 3'b110)) begin
                    target = UNIT_DIV;
                end
            end
            OPC_JAL, OPC_JALR, OPC_BRANCH: target = UNIT_BR;
            default: target = UNIT_ADD;
        endcase
    end

    assign in_ready = is_nop || (credit_cnt[target] != '0);

    always_comb begin
        for (int u = 0; u < 4; u++) begin
            push_now[u] = in_valid && in_ready && !is_nop && (target == unit_e'(u));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rs_push <= '0;
            for (int u = 0; u < 4; u++) begin
                credit_cnt[u] <= CW'(`OOO_RS_DEPTH);
            end
        end else begin
            rs_push <= push_now;
            // Push and credit in one cycle cancel out
            for (int u = 0; u < 4; u++) begin
                credit_cnt[u] <= credit_cnt[u] - CW'(push_now[u]) + CW'(rs_credit[u]);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int u = 0; u < 4; u++) begin
            if (push_now[u]) begin
                rs_opcode[u]     <= in_opcode;
                rs_func3[u]      <= in_func3;
                rs_funct7[u]     <= in_funct7;
                rs_pc[u]         <= in_pc;
                rs_op1[u]        <= in_op1;
                rs_op2[u]        <= in_op2;
                rs_imm[u]        <= in_imm;
                rs_tag[u]        <= in_tag;
                rs_pred_taken[u] <= in_pred_taken;
            end
        end
    end

endmodule

// ==== rtl/reservation_station.sv ====
`include "ooo_cfg.svh"

module reservation_station #(
    parameter ooo_pkg::unit_e unit_kind = ooo_pkg::UNIT_ADD
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rs_push,
    input  ooo_pkg::opcode_e      rs_opcode,
    input  logic [2:0]            rs_func3,
    input  logic [6:0]            rs_funct7,
    input  logic [`OOO_XLEN-1:0]  rs_pc,
    input  logic [`OOO_XLEN-1:0]  rs_op1,
    input  logic [`OOO_XLEN-1:0]  rs_op2,
    input  logic [`OOO_XLEN-1:0]  rs_imm,
    input  logic [`OOO_TAG_W-1:0] rs_tag,
    input  logic                  rs_pred_taken,
    output logic                  rs_credit,
    input  logic                  busy,
    output logic                  iss_valid,
    output ooo_pkg::opcode_e      iss_opcode,
    output logic [2:0]            iss_func3,
    output logic [6:0]            iss_funct7,
    output logic [`OOO_XLEN-1:0]  iss_pc,
    output logic [`OOO_XLEN-1:0]  iss_op1,
    output logic [`OOO_XLEN-1:0]  iss_op2,
    output logic [`OOO_XLEN-1:0]  iss_imm,
    output logic [`OOO_TAG_W-1:0] iss_tag,
    output logic                  iss_pred_taken
);
    import ooo_pkg::*;

    localparam int DEPTH = `OOO_RS_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    opcode_e               q_opcode [DEPTH];
    logic [2:0]            q_func3 [DEPTH];
    logic [6:0]            q_funct7 [DEPTH];
    logic [`OOO_XLEN-1:0]  q_pc [DEPTH];
    logic [`OOO_XLEN-1:0]  q_op1 [DEPTH];
    logic [`OOO_XLEN-1:0]  q_op2 [DEPTH];
    logic [`OOO_XLEN-1:0]  q_imm [DEPTH];
    logic [`OOO_TAG_W-1:0] q_tag [DEPTH];
    logic                  q_pred [DEPTH];
    logic [PTR_W-1:0]      head;
    logic [PTR_W-1:0]      tail;
    logic [CNT_W-1:0]      count;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Head goes out whenever the unit is free
    assign iss_valid = (count != '0) && !busy;
    assign rs_credit = iss_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (rs_push) begin
                tail <= next_ptr(tail);
            end
            if (iss_valid) begin
                head <= next_ptr(head);
            end
            count <= count + CNT_W'(rs_push) - CNT_W'(iss_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (rs_push) begin
            q_opcode[tail] <= rs_opcode;
            q_func3[tail]  <= rs_func3;
            q_funct7[tail] <= rs_funct7;
            q_op1[tail]    <= rs_op1;
            q_op2[tail]    <= rs_op2;
            q_imm[tail]    <= rs_imm;
            q_tag[tail]    <= rs_tag;
            // Only branches need pc and the prediction
            q_pc[tail]     <= (unit_kind == UNIT_BR) ? rs_pc : '0;
            q_pred[tail]   <= (unit_kind == UNIT_BR) ? rs_pred_taken : 1'b0;
        end
    end

    assign iss_opcode     = q_opcode[head];
    assign iss_func3      = q_func3[head];
    assign iss_funct7     = q_funct7[head];
    assign iss_pc         = q_pc[head];
    assign iss_op1        = q_op1[head];
    assign iss_op2        = q_op2[head];
    assign iss_imm        = q_imm[head];
    assign iss_tag        = q_tag[head];
    assign iss_pred_taken = q_pred[head];

endmodule

// ==== rtl/exec_unit.sv ====
`include "ooo_cfg.svh"

module exec_unit #(
    parameter ooo_pkg::unit_e unit_kind = ooo_pkg::UNIT_ADD
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  iss_valid,
    input  ooo_pkg::opcode_e      iss_opcode,
    input  logic [2:0]            iss_func3,
    input  logic [6:0]            iss_funct7,
    input  logic [`OOO_XLEN-1:0]  iss_pc,
    input  logic [`OOO_XLEN-1:0]  iss_op1,
    input  logic [`OOO_XLEN-1:0]  iss_op2,
    input  logic [`OOO_XLEN-1:0]  iss_imm,
    input  logic [`OOO_TAG_W-1:0] iss_tag,
    input  logic                  iss_pred_taken,
    output logic                  busy,
    output logic                  cdb_req,
    output logic [`OOO_TAG_W-1:0] res_tag,
    output logic [`OOO_XLEN-1:0]  res_data,
    output logic                  res_mispredict,
    input  logic                  cdb_gnt
);
    import ooo_pkg::*;

    localparam int XLEN = `OOO_XLEN;
    localparam int LAT = (unit_kind == UNIT_MUL) ? `OOO_MUL_LAT :
                         (unit_kind == UNIT_DIV) ? `OOO_DIV_LAT :
                         (unit_kind == UNIT_BR)  ? `OOO_BR_LAT  : `OOO_ADD_LAT;
    localparam int CNT_W = $clog2(LAT + 1);
    localparam logic [XLEN-1:0] MIN_INT = {1'b1, {(XLEN - 1){1'b0}}};

    typedef enum logic [1:0] {IDLE, BUSY, WAIT_BUS} state_e;

    state_e           state;
    logic [CNT_W-1:0] cnt;
    logic [XLEN-1:0]  op_b;
    logic [XLEN-1:0]  calc_data;
    logic             taken;

    always_comb begin
        op_b = (iss_opcode == OPC_OP_IMM) ? iss_imm : iss_op2;
        calc_data = '0;
        taken = 1'b0;
        case (unit_kind)
            UNIT_ADD: begin
                case (iss_func3)
                    3'b000: calc_data = (iss_opcode == OPC_OP && iss_funct7[5]) ?
                                        iss_op1 - op_b : iss_op1 + op_b;
                    3'b001: calc_data = iss_op1 << op_b[4:0];
                    3'b010: calc_data = XLEN'($signed(iss_op1) < $signed(op_b));
                    3'b011: calc_data = XLEN'(iss_op1 < op_b);
                    3'b100: calc_data = iss_op1 ^ op_b;
                    3'b101: calc_data = iss_funct7[5] ? $unsigned($signed(iss_op1) >>> op_b[4:0])
                                                      : iss_op1 >> op_b[4:0];
                    3'b110: calc_data = iss_op1 | op_b;
                    default: calc_data = iss_op1 & op_b;
                endcase
                if (iss_opcode == OPC_LUI) begin
                    calc_data = iss_imm;
                end
            end
            UNIT_MUL: calc_data = iss_op1 * iss_op2;
            UNIT_DIV: begin
                // Division by zero and signed overflow per RV32M
                if (iss_op2 == '0) begin
                    calc_data = (iss_func3 == 3'b110) ? iss_op1 : '1;
                end else if (iss_op1 == MIN_INT && iss_op2 == '1) begin
                    calc_data = (iss_func3 == 3'b110) ? '0 : iss_op1;
                end else if (iss_func3 == 3'b110) begin
                    calc_data = $unsigned($signed(iss_op1) % $signed(iss_op2));
                end else begin
                    calc_data = $unsigned($signed(iss_op1) / $signed(iss_op2));
                end
            end
            default: begin
                calc_data = iss_pc + XLEN'(4);
                case (iss_func3)
                    3'b000: taken = iss_op1 == iss_op2;
                    3'b001: taken = iss_op1 != iss_op2;
                    3'b100: taken = $signed(iss_op1) < $signed(iss_op2);
                    3'b101: taken = $signed(iss_op1) >= $signed(iss_op2);
                    3'b110: taken = iss_op1 < iss_op2;
                    3'b111: taken = iss_op1 >= iss_op2;
                    default: taken = 1'b0;
                endcase
                if (iss_opcode != OPC_BRANCH) begin
                    taken = 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (iss_valid) begin
                        if (LAT == 1) begin
                            state <= WAIT_BUS;
                        end else begin
                            state <= BUSY;
                            cnt   <= CNT_W'(LAT - 1);
                        end
                    end
                end
                BUSY: begin
                    if (cnt == CNT_W'(1)) begin
                        state <= WAIT_BUS;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                WAIT_BUS: begin
                    if (cdb_gnt) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Result held until the bus takes it
    always_ff @(posedge clk) begin
        if (state == IDLE && iss_valid) begin
            res_tag        <= iss_tag;
            res_data       <= calc_data;
            res_mispredict <= (unit_kind == UNIT_BR) && (taken != iss_pred_taken);
        end
    end

    assign busy    = (state != IDLE);
    assign cdb_req = (state == WAIT_BUS);

endmodule

// ==== rtl/cdb_arbiter.sv ====
module cdb_arbiter (
    input  logic       clk,
    input  logic       reset,
    input  logic [3:0] cdb_req,
    output logic [3:0] cdb_gnt
);
    logic [1:0] ptr;
    logic [1:0] idx;
    logic [1:0] winner;
    logic       found;

    // Scan from the priority pointer, first requester wins
    always_comb begin
        cdb_gnt = '0;
        found   = 1'b0;
        winner  = ptr;
        idx     = ptr;
        for (int i = 0; i < 4; i++) begin
            idx = ptr + 2'(i);
            if (!found && cdb_req[idx]) begin
                cdb_gnt[idx] = 1'b1;
                found        = 1'b1;
                winner       = idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= 2'd0;
        end else if (found) begin
            // last winner drops to lowest priority
            ptr <= winner + 2'd1;
        end
    end

endmodule

// ==== rtl/ooo_exec_top.sv ====
`include "ooo_cfg.svh"

module ooo_exec_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  ooo_pkg::opcode_e      in_opcode,
    input  logic [2:0]            in_func3,
    input  logic [6:0]            in_funct7,
    input  logic [`OOO_XLEN-1:0]  in_pc,
    input  logic [`OOO_XLEN-1:0]  in_op1,
    input  logic [`OOO_XLEN-1:0]  in_op2,
    input  logic [`OOO_XLEN-1:0]  in_imm,
    input  logic [`OOO_TAG_W-1:0] in_tag,
    input  logic                  in_pred_taken,
    output logic                  in_ready,
    output logic                  cdb_valid,
    output logic [`OOO_TAG_W-1:0] cdb_tag,
    output logic [`OOO_XLEN-1:0]  cdb_data,
    output logic                  cdb_mispredict,
    output ooo_pkg::unit_e        cdb_unit
);
    import ooo_pkg::*;

    logic [3:0]            rs_push, rs_credit, rs_pred_taken;
    opcode_e               rs_opcode [4];
    logic [2:0]            rs_func3 [4];
    logic [6:0]            rs_funct7 [4];
    logic [`OOO_XLEN-1:0]  rs_pc [4], rs_op1 [4], rs_op2 [4], rs_imm [4];
    logic [`OOO_TAG_W-1:0] rs_tag [4];
    logic [3:0]            iss_valid, iss_pred_taken, busy;
    opcode_e               iss_opcode [4];
    logic [2:0]            iss_func3 [4];
    logic [6:0]            iss_funct7 [4];
    logic [`OOO_XLEN-1:0]  iss_pc [4], iss_op1 [4], iss_op2 [4], iss_imm [4];
    logic [`OOO_TAG_W-1:0] iss_tag [4], res_tag [4];
    logic [`OOO_XLEN-1:0]  res_data [4];
    logic [3:0]            res_mispredict, cdb_req, cdb_gnt;
    unit_e                 gnt_idx;

    dispatch_decoder dispatch_decoder_inst (.*);

    for (genvar u = 0; u < 4; u++) begin : gen_unit
        reservation_station #(.unit_kind(unit_e'(u))) rs_inst (
            .clk, .reset,
            .rs_push(rs_push[u]), .rs_opcode(rs_opcode[u]), .rs_func3(rs_func3[u]),
            .rs_funct7(rs_funct7[u]), .rs_pc(rs_pc[u]), .rs_op1(rs_op1[u]),
            .rs_op2(rs_op2[u]), .rs_imm(rs_imm[u]), .rs_tag(rs_tag[u]),
            .rs_pred_taken(rs_pred_taken[u]), .rs_credit(rs_credit[u]), .busy(busy[u]),
            .iss_valid(iss_valid[u]), .iss_opcode(iss_opcode[u]), .iss_func3(iss_func3[u]),
            .iss_funct7(iss_funct7[u]), .iss_pc(iss_pc[u]), .iss_op1(iss_op1[u]),
            .iss_op2(iss_op2[u]), .iss_imm(iss_imm[u]), .iss_tag(iss_tag[u]),
            .iss_pred_taken(iss_pred_taken[u])
        );
        exec_unit #(.unit_kind(unit_e'(u))) eu_inst (
            .clk, .reset,
            .iss_valid(iss_valid[u]), .iss_opcode(iss_opcode[u]), .iss_func3(iss_func3[u]),
            .iss_funct7(iss_funct7[u]), .iss_pc(iss_pc[u]), .iss_op1(iss_op1[u]),
            .iss_op2(iss_op2[u]), .iss_imm(iss_imm[u]), .iss_tag(iss_tag[u]),
            .iss_pred_taken(iss_pred_taken[u]), .busy(busy[u]), .cdb_req(cdb_req[u]),
            .res_tag(res_tag[u]), .res_data(res_data[u]),
            .res_mispredict(res_mispredict[u]), .cdb_gnt(cdb_gnt[u])
        );
    end

    cdb_arbiter cdb_arbiter_inst (.clk, .reset, .cdb_req, .cdb_gnt);

    // Grant is one-hot, pick the winning unit
    always_comb begin
        gnt_idx = UNIT_ADD;
        for (int u = 0; u < 4; u++) begin
            if (cdb_gnt[u]) begin
                gnt_idx = unit_e'(u);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= |cdb_gnt;
        end
    end

    always_ff @(posedge clk) begin
        cdb_tag        <= res_tag[gnt_idx];
        cdb_data       <= res_data[gnt_idx];
        cdb_mispredict <= res_mispredict[gnt_idx];
        cdb_unit       <= gnt_idx;
    end

endmodule

// ==== test/tb_ooo_vectors.svh ====
`ifndef TB_OOO_VECTORS_SVH
`define TB_OOO_VECTORS_SVH

// Columns: opcode, func3, funct7, pc, op1, op2, imm, pred_taken, exp data, exp mispredict
// Row index is the tag
localparam int NUM_VEC = 34;

localparam vec_t VECS [NUM_VEC] = '{
    '{OPC_OP,     3'd0, 7'h00, 32'h0,   32'd7,        32'd5,        32'h0, 1'b0, 32'd12, 1'b0},
    '{OPC_OP,     3'd0, 7'h20, 32'h0,   32'd5,        32'd7,        32'h0, 1'b0, 32'hFFFFFFFE, 1'b0},
    '{OPC_OP,     3'd1, 7'h00, 32'h0,   32'h1,        32'h24,       32'h0, 1'b0, 32'h10, 1'b0},
    '{OPC_OP,     3'd2, 7'h00, 32'h0,   32'hFFFFFFFF, 32'h1,        32'h0, 1'b0, 32'h1, 1'b0},
    '{OPC_OP,     3'd3, 7'h00, 32'h0,   32'hFFFFFFFF, 32'h1,        32'h0, 1'b0, 32'h0, 1'b0},
    '{OPC_OP,     3'd4, 7'h00, 32'h0,   32'hF0F0F0F0, 32'hFF00FF00, 32'h0, 1'b0, 32'h0FF00FF0, 1'b0},
    '{OPC_OP,     3'd5, 7'h00, 32'h0,   32'h80000000, 32'h4,        32'h0, 1'b0, 32'h08000000, 1'b0},
    '{OPC_OP,     3'd5, 7'h20, 32'h0,   32'h80000000, 32'h4,        32'h0, 1'b0, 32'hF8000000, 1'b0},
    '{OPC_OP,     3'd6, 7'h00, 32'h0,   32'h0F00,     32'h00F0,     32'h0, 1'b0, 32'h0FF0, 1'b0},
    '{OPC_OP,     3'd7, 7'h00, 32'h0,   32'hFF00FF00, 32'h0FF00FF0, 32'h0, 1'b0, 32'h0F000F00, 1'b0},
    '{OPC_OP_IMM, 3'd0, 7'h00, 32'h0,   32'd100, 32'h12345678, 32'hFFFFFFF6, 1'b0, 32'h5A, 1'b0},
    '{OPC_LUI,    3'd0, 7'h00, 32'h0,   32'h55,  32'h0,        32'h12345000, 1'b0, 32'h12345000, 1'b0},
    '{OPC_NOP,    3'd0, 7'h00, 32'h0,   32'h0,        32'h0,        32'h0, 1'b0, 32'h0, 1'b0},
    // Multiplier, low product
    '{OPC_OP,     3'd0, 7'h01, 32'h0,   32'd6,        32'd7,        32'h0, 1'b0, 32'h2A, 1'b0},
    '{OPC_OP,     3'd0, 7'h01, 32'h0,   32'hFFFFFFFF, 32'd3,        32'h0, 1'b0, 32'hFFFFFFFD, 1'b0},
    // Divide burst, deeper than one station
    '{OPC_OP,     3'd4, 7'h01, 32'h0,   32'hFFFFFFEC, 32'd6,        32'h0, 1'b0, 32'hFFFFFFFD, 1'b0},
    '{OPC_OP,     3'd6, 7'h01, 32'h0,   32'hFFFFFFEC, 32'd6,        32'h0, 1'b0, 32'hFFFFFFFE, 1'b0},
    '{OPC_OP,     3'd4, 7'h01, 32'h0,   32'd5,        32'h0,        32'h0, 1'b0, 32'hFFFFFFFF, 1'b0},
    '{OPC_OP,     3'd6, 7'h01, 32'h0,   32'd5,        32'h0,        32'h0, 1'b0, 32'd5, 1'b0},
    '{OPC_OP,     3'd4, 7'h01, 32'h0,   32'h80000000, 32'hFFFFFFFF, 32'h0, 1'b0, 32'h80000000, 1'b0},
    '{OPC_OP,     3'd6, 7'h01, 32'h0,   32'h80000000, 32'hFFFFFFFF, 32'h0, 1'b0, 32'h0, 1'b0},
    // Branches, data is pc + 4
    '{OPC_BRANCH, 3'd0, 7'h00, 32'h100, 32'd3,        32'd3,        32'h0, 1'b1, 32'h104, 1'b0},
    '{OPC_BRANCH, 3'd1, 7'h00, 32'h200, 32'd3,        32'd3,        32'h0, 1'b1, 32'h204, 1'b1},
    '{OPC_BRANCH, 3'd4, 7'h00, 32'h300, 32'hFFFFFFFF, 32'h1,        32'h0, 1'b0, 32'h304, 1'b1},
    '{OPC_BRANCH, 3'd5, 7'h00, 32'h400, 32'hFFFFFFFF, 32'h1,        32'h0, 1'b0, 32'h404, 1'b0},
    '{OPC_BRANCH, 3'd6, 7'h00, 32'h500, 32'hFFFFFFFF, 32'h1,        32'h0, 1'b1, 32'h504, 1'b1},
    '{OPC_BRANCH, 3'd7, 7'h00, 32'h600, 32'hFFFFFFFF, 32'h1,        32'h0, 1'b1, 32'h604, 1'b0},
    '{OPC_JAL,    3'd0, 7'h00, 32'h700, 32'h0,        32'h0,        32'h0, 1'b0, 32'h704, 1'b1},
    '{OPC_JALR,   3'd0, 7'h00, 32'h800, 32'h1000,     32'h0,        32'h0, 1'b1, 32'h804, 1'b0},
    // Mixed burst across all four units
    '{OPC_OP,     3'd0, 7'h00, 32'h0,   32'd1,        32'd1,        32'h0, 1'b0, 32'd2, 1'b0},
    '{OPC_OP,     3'd0, 7'h01, 32'h0,   32'h10000,    32'h10000,    32'h0, 1'b0, 32'h0, 1'b0},
    '{OPC_OP,     3'd4, 7'h01, 32'h0,   32'd7,        32'hFFFFFFFE, 32'h0, 1'b0, 32'hFFFFFFFD, 1'b0},
    '{OPC_JAL,    3'd0, 7'h00, 32'h900, 32'h0,        32'h0,        32'h0, 1'b1, 32'h904, 1'b0},
    '{OPC_NOP,    3'd0, 7'h00, 32'h0,   32'h0,        32'h0,        32'h0, 1'b0, 32'h0, 1'b0}
};

`endif

// ==== test/tb_ooo_exec.sv ====
`include "ooo_cfg.svh"

module tb_ooo_exec;
    import ooo_pkg::*;

    localparam int PERIOD = 100;

    typedef struct packed {
        opcode_e     opcode;
        logic [2:0]  func3;
        logic [6:0]  funct7;
        logic [31:0] pc;
        logic [31:0] op1;
        logic [31:0] op2;
        logic [31:0] imm;
        logic        pred;
        logic [31:0] exp_data;
        logic        exp_misp;
    } vec_t;

    `include "tb_ooo_vectors.svh"

    // Reset time plus a generous per-row budget
    localparam int WATCHDOG = (NUM_VEC * (`OOO_DIV_LAT + 8) + 16) * PERIOD;
    // A full divide station plus the unit, each waiting on the bus
    localparam int DRAIN_CYCLES = (`OOO_RS_DEPTH + 2) * (`OOO_DIV_LAT + 4);

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    opcode_e               in_opcode;
    logic [2:0]            in_func3;
    logic [6:0]            in_funct7;
    logic [`OOO_XLEN-1:0]  in_pc;
    logic [`OOO_XLEN-1:0]  in_op1;
    logic [`OOO_XLEN-1:0]  in_op2;
    logic [`OOO_XLEN-1:0]  in_imm;
    logic [`OOO_TAG_W-1:0] in_tag;
    logic                  in_pred_taken;
    logic                  in_ready;
    logic                  cdb_valid;
    logic [`OOO_TAG_W-1:0] cdb_tag;
    logic [`OOO_XLEN-1:0]  cdb_data;
    logic                  cdb_mispredict;
    unit_e                 cdb_unit;

    bit expected_tag [NUM_VEC];
    bit seen_tag [NUM_VEC];
    int last_tag [4];
    int mismatches;
    int other_errors;
    int results;
    int num_expected;
    int stall_cycles;

    ooo_exec_top ooo_exec_top_inst (.*);

    always #(PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            mismatches++;
        end
    endtask

    // Target unit of a row by the RV32 routing rules
    function automatic unit_e unit_for_row(input int idx);
        unit_e target;
        target = UNIT_ADD;
        if (VECS[idx].opcode inside {OPC_JAL, OPC_JALR, OPC_BRANCH}) begin
            target = UNIT_BR;
        end else if (VECS[idx].opcode == OPC_OP && VECS[idx].funct7 == 7'h01) begin
            if (VECS[idx].func3 == 3'd0) begin
                target = UNIT_MUL;
            end else if (VECS[idx].func3 inside {3'd4, 3'd6}) begin
                target = UNIT_DIV;
            end
        end
        return target;
    endfunction

    // Holds the row on the inputs until the decoder takes it
    task automatic send_row(input int idx);
        bit accepted;
        accepted = 1'b0;
        expected_tag[idx] = (VECS[idx].opcode != OPC_NOP);
        if (expected_tag[idx]) begin
            num_expected++;
        end
        in_valid      = 1'b1;
        in_opcode     = VECS[idx].opcode;
        in_func3      = VECS[idx].func3;
        in_funct7     = VECS[idx].funct7;
        in_pc         = VECS[idx].pc;
        in_op1        = VECS[idx].op1;
        in_op2        = VECS[idx].op2;
        in_imm        = VECS[idx].imm;
        in_tag        = `OOO_TAG_W'(idx);
        in_pred_taken = VECS[idx].pred;
        while (!accepted) begin
            @(negedge clk);
            accepted = in_ready;
            if (!accepted) begin
                stall_cycles++;
            end
            @(posedge clk);
            #10;
        end
        in_valid = 1'b0;
    endtask

    task automatic record_result();
        int    tag;
        unit_e exp_unit;
        tag = int'(cdb_tag);
        if (tag >= NUM_VEC || !expected_tag[tag]) begin
            $display("Unexpected CDB result for tag %0d", tag);
            other_errors++;
        end else if (seen_tag[tag]) begin
            $display("Tag %0d was delivered on the CDB more than once", tag);
            other_errors++;
        end else begin
            exp_unit = unit_for_row(tag);
            seen_tag[tag] = 1'b1;
            results++;
            check_value($sformatf("row %0d data", tag), VECS[tag].exp_data, cdb_data);
            check_value($sformatf("row %0d mispredict", tag), 32'(VECS[tag].exp_misp),
                        32'(cdb_mispredict));
            check_value($sformatf("row %0d unit", tag), 32'(exp_unit), 32'(cdb_unit));
            if (tag <= last_tag[exp_unit]) begin
                $display("Tag %0d left unit %s ahead of older tag %0d", last_tag[exp_unit],
                         exp_unit.name(), tag);
                other_errors++;
            end
            last_tag[exp_unit] = tag;
        end
    endtask

    // cdb_valid is registered, mid-cycle it is settled
    always @(negedge clk) begin
        if (!reset && cdb_valid) begin
            record_result();
        end
    end

    initial begin
        #(WATCHDOG);
        $display("Timeout: %0d of %0d results arrived before the time limit",
                 results, num_expected);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int gap;
        int drain;
        void'($urandom(58743));
        clk = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        in_opcode = OPC_NOP;
        in_func3 = '0;
        in_funct7 = '0;
        in_pc = '0;
        in_op1 = '0;
        in_op2 = '0;
        in_imm = '0;
        in_tag = '0;
        in_pred_taken = 1'b0;
        for (int u = 0; u < 4; u++) begin
            last_tag[u] = -1;
        end
        repeat (16) @(posedge clk);
        #10;
        reset = 1'b0;
        for (int i = 0; i < NUM_VEC; i++) begin
            send_row(i);
            gap = $urandom % 2;
            repeat (gap) begin
                @(posedge clk);
                #10;
            end
        end
        drain = 0;
        while (results != num_expected && drain < DRAIN_CYCLES) begin
            @(posedge clk);
            drain++;
        end
        // Leave room for any stray result after the last one
        repeat (20) @(posedge clk);
        for (int i = 0; i < NUM_VEC; i++) begin
            if (expected_tag[i] && !seen_tag[i]) begin
                $display("No CDB result was seen for row %0d", i);
                other_errors++;
            end
        end
        if (stall_cycles == 0) begin
            $display("in_ready never dropped during the divide burst");
            other_errors++;
        end
        $display("Done: %0d results, %0d value mismatches, %0d other errors, %0d stall cycles",
                 results, mismatches, other_errors, stall_cycles);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+rtl
+incdir+test
rtl/ooo_pkg.sv
rtl/dispatch_decoder.sv
rtl/reservation_station.sv
rtl/exec_unit.sv
rtl/cdb_arbiter.sv
rtl/ooo_exec_top.sv
test/tb_ooo_exec.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tb_ooo_exec
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SRCS      = $(wildcard rtl/*.sv rtl/*.svh test/*.sv test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
